//--- Makefile
# Verilator simulation of the CLIC subsystem

SIM := obj_dir/clic_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the CLIC testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module clic_tb -f clic_top.f -o clic_sim
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- clic_top.f
logic/clic_pkg.sv
logic/clic_offer_if.sv
logic/clic_regfile.sv
logic/clic_arbiter.sv
logic/clic_hart_ctrl.sv
logic/clic_top.sv
verification/clic_tb.sv

//--- logic/clic_arbiter.sv
// ------------------------------------------------
// CLIC arbiter
// Highest-level pick, registered offer,
// kill request and edge pending clear
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module clic_arbiter (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Per-source state from the regfile
  input  logic [clic_pkg::num_src-1:0]              pend_i,
  input  logic [clic_pkg::num_src-1:0]              en_i,
  input  logic [clic_pkg::num_src-1:0]              edge_i,
  input  clic_pkg::priv_t  [clic_pkg::num_src-1:0]  priv_i,
  input  clic_pkg::level_t [clic_pkg::num_src-1:0]  level_i,
  // Offer to the hart side
  clic_offer_if.arbiter                             offer,
  // Pending clear for retired edge sources
  output logic                                      clr_valid_o,
  output clic_pkg::irq_id_t                         clr_id_o
);
  import clic_pkg::*;

  logic    cand_valid;  // Some source is enabled and pending
  irq_id_t cand_id;
  level_t  cand_level;
  logic    valid_q;
  irq_id_t id_q;
  level_t  level_q;
  priv_t   priv_q;
  logic    kill_q;      // Kill raised and still waiting
  logic    offer_live;  // Offered source still enabled and pending
  logic    need_kill;
  logic    retire;      // Core took the offer
  logic    drop;        // Offer leaves this cycle

  // ------------------------------------------------
  // Candidate selection
  // ------------------------------------------------
  // Strict compare keeps the lowest ID on ties
  always_comb begin : pick
    cand_valid = 1'b0;
    cand_id    = '0;
    cand_level = '0;
    for (int i = 0; i < num_src; i++) begin
      if (pend_i[i] && en_i[i] && (!cand_valid || (level_i[i] > cand_level))) begin
        cand_valid = 1'b1;
        cand_id    = irq_id_t'(i);
        cand_level = level_i[i];
      end
    end
  end

  // ------------------------------------------------
  // Offer control
  // ------------------------------------------------
  assign offer_live = pend_i[id_q] & en_i[id_q];
  // A live offer is always a candidate, so compare IDs only then
  assign need_kill  = valid_q & (~offer_live | (cand_id != id_q));
  assign retire     = valid_q & offer.ready;
  assign drop       = retire | (valid_q & offer.kill_ack);

  // Sticky until acked or retired
  assign offer.kill_req = valid_q & (need_kill | kill_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      kill_q  <= 1'b0;
      id_q    <= '0;
      level_q <= '0;
      priv_q  <= '0;
    end else begin
      kill_q <= offer.kill_req & ~drop;
      if (drop) begin
        valid_q <= 1'b0;  // Next pick waits one cycle
      end else if (!valid_q && cand_valid) begin
        valid_q <= 1'b1;
        id_q    <= cand_id;   // Frozen while offered
        level_q <= cand_level;
        priv_q  <= priv_i[cand_id];
      end
    end
  end

  assign offer.valid = valid_q;
  assign offer.id    = id_q;
  assign offer.level = level_q;
  assign offer.priv  = priv_q;

  // Level sources clear by themselves
  assign clr_valid_o = retire & edge_i[id_q];
  assign clr_id_o    = id_q;

endmodule

`default_nettype wire

//--- logic/clic_hart_ctrl.sv
// ------------------------------------------------
// CLIC hart-side controller
// Privilege threshold check, cause packing,
// in-flight tracking and kill acknowledge
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module clic_hart_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Hart state
  input  clic_pkg::priv_t   priv_lvl_i,    // Current privilege
  input  clic_pkg::level_t  mintthresh_i,  // M-mode threshold
  input  clic_pkg::level_t  sintthresh_i,  // S-mode threshold
  input  clic_pkg::level_t  mil_i,         // M running level
  input  clic_pkg::level_t  sil_i,         // S running level
  input  logic              sie_i,         // S-mode global enable
  // Offer from the arbiter
  clic_offer_if.hart        offer,
  // Core side
  input  logic              irq_ready_i,
  output logic              irq_req_o,
  output clic_pkg::cause_t  irq_cause_o
);
  import clic_pkg::*;

  level_t max_mthresh;  // Effective M threshold
  level_t max_sthresh;  // Effective S threshold
  logic   accept;       // Offer passes the privilege rules
  logic   inflight_q;
  logic   inflight_d;

  // ------------------------------------------------
  // Thresholds
  // ------------------------------------------------
  // Running level counts as a threshold too
  assign max_mthresh = (mintthresh_i > mil_i) ? mintthresh_i : mil_i;
  assign max_sthresh = (sintthresh_i > sil_i) ? sintthresh_i : sil_i;

  // ------------------------------------------------
  // Acceptance
  // ------------------------------------------------
  always_comb begin : accept_rules
    accept = 1'b0;
    case (priv_lvl_i)
      priv_m: begin
        // Only M targets above the M threshold
        if (offer.priv == priv_m) begin
          accept = (offer.level > max_mthresh);
        end
      end
      priv_s: begin
        if (offer.priv == priv_m) begin
          accept = 1'b1;  // Higher mode always preempts
        end else if (offer.priv == priv_s) begin
          accept = sie_i && (offer.level > max_sthresh);
        end
      end
      priv_u: begin
        // Everything above U, no threshold
        accept = (offer.priv == priv_m) || (offer.priv == priv_s);
      end
      default: accept = 1'b0;  // Reserved privilege
    endcase
  end

  // Request withdrawn as soon as the arbiter wants a kill
  assign irq_req_o = offer.valid & accept & ~offer.kill_req;

  // ------------------------------------------------
  // Cause word
  // ------------------------------------------------
  assign irq_cause_o = {
    1'b1,                       // Interrupt flag
    5'b0,
    offer.priv,                 // Bits 25:24
    offer.level,                // Bits 23:16
    {(16 - id_w){1'b0}},
    offer.id                    // Source ID
  };

  // ------------------------------------------------
  // Kill control
  // ------------------------------------------------
  assign offer.ready = irq_ready_i;  // Core handshake straight through

  // Set while the core sees a request it has not taken
  // Ready or a withdrawn request clears it
  assign inflight_d = irq_req_o & ~irq_ready_i;

  // Safe only with nothing in flight and nothing taken now
  assign offer.kill_ack = offer.kill_req & ~inflight_q & ~irq_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/clic_offer_if.sv
// ------------------------------------------------
// Interrupt offer and kill handshake
// between the arbiter and the hart controller
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface clic_offer_if;
  import clic_pkg::*;

  logic    valid;     // Offer present
  irq_id_t id;        // Offered source
  level_t  level;
  priv_t   priv;      // Target privilege
  logic    kill_req;  // Arbiter wants the offer back
  logic    ready;     // Core took the offer
  logic    kill_ack;  // Kill is safe

  // Offer side
  modport arbiter (
    output valid, id, level, priv, kill_req,
    input  ready, kill_ack
  );

  // Hart side
  modport hart (
    input  valid, id, level, priv, kill_req,
    output ready, kill_ack
  );

endinterface

`default_nettype wire

//--- logic/clic_pkg.sv
// ------------------------------------------------
// Shared CLIC definitions
// Source count, ID and level widths, bus types
// Privilege encodings and register map constants
// ------------------------------------------------

`default_nettype none

package clic_pkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------
  localparam int unsigned num_src  = 16;  // Interrupt sources
  localparam int unsigned id_w     = 4;   // Source ID width
  localparam int unsigned wb_sel_w = 4;   // Byte lanes per bus word

  // Meaningful vector widths
  typedef logic [id_w-1:0] irq_id_t;
  typedef logic [7:0]      level_t;       // Level or threshold
  typedef logic [1:0]      priv_t;
  typedef logic [31:0]     cause_t;       // Cause word to the core
  typedef logic [11:0]     wb_addr_t;     // Byte address
  typedef logic [31:0]     wb_data_t;

  // ------------------------------------------------
  // Privilege levels
  // ------------------------------------------------
  localparam priv_t priv_u = 2'd0;
  localparam priv_t priv_s = 2'd1;
  localparam priv_t priv_m = 2'd3;        // 2 is reserved

  // ------------------------------------------------
  // Register map
  // ------------------------------------------------
  // One word per source at byte address 4n
  localparam wb_addr_t map_end = 12'h040; // First unmapped address

  // Attribute byte fields
  localparam int unsigned attr_trig_bit = 0;  // 1 rising edge, 0 level
  localparam int unsigned attr_priv_lsb = 6;  // Target priv in bits 7:6

  // Cause word layout
  localparam int unsigned cause_priv_lsb  = 24;
  localparam int unsigned cause_level_lsb = 16;

endpackage

`default_nettype wire

//--- logic/clic_regfile.sv
// ------------------------------------------------
// CLIC register file with Wishbone classic slave
// Per-source pending, enable, attribute, level
// Source capture and edge detection
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module clic_regfile (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Wishbone classic slave
  input  logic                                      wb_cyc_i,
  input  logic                                      wb_stb_i,
  input  logic                                      wb_we_i,
  input  clic_pkg::wb_addr_t                        wb_adr_i,
  input  clic_pkg::wb_data_t                        wb_dat_i,
  input  logic [clic_pkg::wb_sel_w-1:0]             wb_sel_i,
  output clic_pkg::wb_data_t                        wb_dat_o,
  output logic                                      wb_ack_o,
  // Raw interrupt wires
  input  logic [clic_pkg::num_src-1:0]              irq_src_i,
  // Pending clear from the arbiter
  input  logic                                      clr_valid_i,
  input  clic_pkg::irq_id_t                         clr_id_i,
  // Per-source state to the arbiter
  output logic [clic_pkg::num_src-1:0]              pend_o,
  output logic [clic_pkg::num_src-1:0]              en_o,
  output logic [clic_pkg::num_src-1:0]              edge_o,
  output clic_pkg::priv_t  [clic_pkg::num_src-1:0]  priv_o,
  output clic_pkg::level_t [clic_pkg::num_src-1:0]  level_o
);
  import clic_pkg::*;

  logic                    req;        // New bus request this cycle
  logic                    ack_q;
  logic                    in_map;     // Address hits a source word
  irq_id_t                 sel_id;     // Addressed source
  wb_data_t                rdata_q;
  logic [num_src-1:0]      wr_src;     // Write strobe per source
  logic [num_src-1:0]      src_q;      // Delayed wires for edges
  logic [num_src-1:0]      src_rise;
  logic [num_src-1:0]      pend_q;
  logic [num_src-1:0]      en_q;
  logic [num_src-1:0][7:0] attr_q;
  level_t [num_src-1:0]    level_q;

  // ------------------------------------------------
  // Bus decode
  // ------------------------------------------------
  assign req    = wb_cyc_i & wb_stb_i & ~ack_q;  // Ignore stb during ack
  assign in_map = (wb_adr_i < map_end);
  assign sel_id = wb_adr_i[id_w+1:2];  // Word index

  always_comb begin
    for (int i = 0; i < num_src; i++) begin
      wr_src[i] = req & wb_we_i & in_map & (sel_id == irq_id_t'(i));
    end
  end

  // Single-cycle ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // Read data captured with the request
  always_ff @(posedge clk_i) begin
    if (req) begin
      if (in_map) begin
        rdata_q <= {level_q[sel_id], attr_q[sel_id],
                    7'b0, en_q[sel_id], 7'b0, pend_q[sel_id]};
      end else begin
        rdata_q <= '0;  // Unmapped reads zero
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = rdata_q;

  // ------------------------------------------------
  // Configuration bytes
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q    <= '0;
      attr_q  <= '0;
      level_q <= '0;
    end else begin
      for (int i = 0; i < num_src; i++) begin
        if (wr_src[i]) begin
          if (wb_sel_i[1]) en_q[i]    <= wb_dat_i[8];      // Enable bit only
          if (wb_sel_i[2]) attr_q[i]  <= wb_dat_i[23:16];
          if (wb_sel_i[3]) level_q[i] <= wb_dat_i[31:24];
        end
      end
    end
  end

  // ------------------------------------------------
  // Pending bits
  // ------------------------------------------------
  assign src_rise = irq_src_i & ~src_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q  <= '0;
      pend_q <= '0;
    end else begin
      src_q <= irq_src_i;
      for (int i = 0; i < num_src; i++) begin
        if (!attr_q[i][attr_trig_bit]) begin
          pend_q[i] <= irq_src_i[i];  // Level mode tracks the wire
        end else if (wr_src[i] && wb_sel_i[0]) begin
          pend_q[i] <= wb_dat_i[0];  // Software write beats the clear
        end else if (src_rise[i]) begin
          pend_q[i] <= 1'b1;
        end else if (clr_valid_i && (clr_id_i == irq_id_t'(i))) begin
          pend_q[i] <= 1'b0;  // Retired by the core
        end
      end
    end
  end

  // Fields out to the arbiter
  always_comb begin
    for (int i = 0; i < num_src; i++) begin
      edge_o[i] = attr_q[i][attr_trig_bit];
      priv_o[i] = attr_q[i][attr_priv_lsb+1:attr_priv_lsb];
    end
  end

  assign pend_o  = pend_q;
  assign en_o    = en_q;
  assign level_o = level_q;

endmodule

`default_nettype wire

//--- logic/clic_top.sv
// ------------------------------------------------
// CLIC subsystem top level
// Regfile, arbiter and hart controller
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module clic_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Wishbone classic slave
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  clic_pkg::wb_addr_t             wb_adr_i,
  input  clic_pkg::wb_data_t             wb_dat_i,
  input  logic [clic_pkg::wb_sel_w-1:0]  wb_sel_i,
  output clic_pkg::wb_data_t             wb_dat_o,
  output logic                           wb_ack_o,
  // Interrupt wires
  input  logic [clic_pkg::num_src-1:0]   irq_src_i,
  // Hart state from the CSR file
  input  clic_pkg::priv_t                priv_lvl_i,
  input  clic_pkg::level_t               mintthresh_i,
  input  clic_pkg::level_t               sintthresh_i,
  input  clic_pkg::level_t               mil_i,
  input  clic_pkg::level_t               sil_i,
  input  logic                           sie_i,
  // Core side
  output logic                           irq_req_o,
  output clic_pkg::cause_t               irq_cause_o,
  input  logic                           irq_ready_i
);
  import clic_pkg::*;

  logic [num_src-1:0]   pend;
  logic [num_src-1:0]   en;
  logic [num_src-1:0]   edge_sel;  // Edge-triggered sources
  priv_t  [num_src-1:0] priv;
  level_t [num_src-1:0] level;
  logic                 clr_valid;
  irq_id_t              clr_id;

  clic_offer_if u_offer ();

  clic_regfile u_regfile (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o,
    .irq_src_i,
    .clr_valid_i (clr_valid),
    .clr_id_i    (clr_id),
    .pend_o      (pend),
    .en_o        (en),
    .edge_o      (edge_sel),
    .priv_o      (priv),
    .level_o     (level)
  );

  clic_arbiter u_arbiter (
    .clk_i, .rst_ni,
    .pend_i      (pend),
    .en_i        (en),
    .edge_i      (edge_sel),
    .priv_i      (priv),
    .level_i     (level),
    .offer       (u_offer.arbiter),
    .clr_valid_o (clr_valid),
    .clr_id_o    (clr_id)
  );

  clic_hart_ctrl u_hart_ctrl (
    .clk_i, .rst_ni,
    .priv_lvl_i, .mintthresh_i, .sintthresh_i, .mil_i, .sil_i, .sie_i,
    .offer       (u_offer.hart),
    .irq_ready_i,
    .irq_req_o,
    .irq_cause_o
  );

endmodule

`default_nettype wire

//--- verification/clic_tb.sv
// ------------------------------------------------
// Directed testbench for the CLIC subsystem
// Clock, reset, Wishbone tasks, test tasks, report
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module clic_tb;
  import clic_pkg::*;

  localparam int unsigned wait_max = 40;  // Cycles per bounded wait

  logic                clk_i;
  logic                rst_ni;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  wb_addr_t            wb_adr_i;
  wb_data_t            wb_dat_i;
  logic [wb_sel_w-1:0] wb_sel_i;
  wb_data_t            wb_dat_o;
  logic                wb_ack_o;
  logic [num_src-1:0]  irq_src_i;
  priv_t               priv_lvl_i;
  level_t              mintthresh_i;
  level_t              sintthresh_i;
  level_t              mil_i;
  level_t              sil_i;
  logic                sie_i;
  logic                irq_req_o;
  cause_t              irq_cause_o;
  logic                irq_ready_i;

  int unsigned         errors;   // Wrong values
  int unsigned         fails;    // Timeouts and other failures
  int unsigned         seed;
  irq_id_t [3:0]       sel_id;   // Selection test sources
  level_t  [3:0]       sel_lvl;

  clic_top UUT (.*);

  always #2 clk_i = ~clk_i;  // 4 ns period

  // ------------------------------------------------
  // Reporting and reference models
  // ------------------------------------------------
  task automatic value_error(input string test, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("Error %s: expected %h, got %h", test, exp, act);
  endtask

  task automatic plain_error(input string msg);
    fails++;
    $display("%s", msg);
  endtask

  function automatic wb_addr_t addr_of(input irq_id_t id);
    return wb_addr_t'({id, 2'b00});  // One word per source
  endfunction

  // Cause layout: flag, target priv, level, ID
  function automatic cause_t pack_cause(input priv_t tgt, input level_t lvl, input irq_id_t id);
    cause_t c;
    c        = '0;
    c[31]    = 1'b1;
    c[25:24] = tgt;
    c[23:16] = lvl;
    c[3:0]   = id;
    return c;
  endfunction

  // Whether the hart should take an offer now
  function automatic logic takes(input priv_t mode, input priv_t tgt, input level_t lvl);
    level_t mth;
    level_t sth;
    mth = (mintthresh_i > mil_i) ? mintthresh_i : mil_i;
    sth = (sintthresh_i > sil_i) ? sintthresh_i : sil_i;
    if (tgt == priv_u) return 1'b0;
    if (mode == priv_m) return (tgt == priv_m) && (lvl > mth);
    if (mode == priv_s) return (tgt == priv_m) || (sie_i && (lvl > sth));
    return 1'b1;  // U-mode takes M and S targets
  endfunction

  // Highest level wins, lowest ID on ties
  function automatic int unsigned best_slot(input logic [3:0] live);
    int unsigned best;
    best = 4;
    for (int unsigned i = 0; i < 4; i++) begin
      if (live[i] && (best == 4 || sel_lvl[i] > sel_lvl[best] ||
          (sel_lvl[i] == sel_lvl[best] && sel_id[i] < sel_id[best]))) begin
        best = i;
      end
    end
    return best;
  endfunction

  // ------------------------------------------------
  // Bus and wait tasks
  // ------------------------------------------------
  task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                           input logic [wb_sel_w-1:0] sel, output wb_data_t rd);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    do begin
      @(negedge clk_i);
      n++;
    end while (!wb_ack_o && n < wait_max);
    rd = wb_dat_o;  // Valid with the ack
    if (!wb_ack_o) begin
      plain_error($sformatf("Bus access to %h was never acknowledged", adr));
    end else if (n != 1) begin
      plain_error($sformatf("Bus ack to %h came after %0d cycles", adr, n));
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat,
                          input logic [wb_sel_w-1:0] sel);
    wb_data_t unused;
    bus_cycle(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t rd);
    bus_cycle(1'b0, adr, '0, 4'hF, rd);
  endtask

  task automatic wait_req(input logic want, input string test);
    int unsigned n;
    n = 0;
    while (irq_req_o !== want && n < wait_max) begin
      @(negedge clk_i);
      n++;
    end
    if (irq_req_o !== want) plain_error($sformatf("%s: irq_req_o never went %0b", test, want));
  endtask

  // Watch the request stay low for a while
  task automatic no_req(input int unsigned cycles, input string test);
    int unsigned hits;
    hits = 0;
    for (int unsigned i = 0; i < cycles; i++) begin
      @(negedge clk_i);
      if (irq_req_o !== 1'b0) hits++;
    end
    if (hits != 0) plain_error($sformatf("%s: irq_req_o rose when it must stay low", test));
  endtask

  task automatic wait_idle(input string test);
    int unsigned n;
    n = 0;
    while (UUT.u_offer.valid !== 1'b0 && n < wait_max) begin
      @(negedge clk_i);
      n++;
    end
    if (UUT.u_offer.valid !== 1'b0) plain_error($sformatf("%s: offer never went away", test));
  endtask

  // Config bytes only, pending lane left alone
  task automatic set_src(input irq_id_t id, input logic trig, input priv_t tgt,
                         input level_t lvl, input logic en);
    wb_write(addr_of(id), {lvl, tgt, 5'b0, trig, 7'b0, en, 8'h00}, 4'hE);
  endtask

  task automatic clear_all();
    irq_src_i = '0;
    for (int unsigned i = 0; i < num_src; i++) begin
      wb_write(addr_of(irq_id_t'(i)), '0, 4'hF);
    end
    wait_idle("clear_all");
  endtask

  // ------------------------------------------------
  // Tests
  // ------------------------------------------------
  task automatic test_regs();
    wb_data_t            shadow [num_src];  // Expected word per source
    wb_data_t            dat;
    wb_data_t            rd;
    logic [wb_sel_w-1:0] sel;
    irq_id_t             id;
    for (int unsigned i = 0; i < num_src; i += 5) begin
      id         = irq_id_t'(i);
      dat        = $urandom();
      shadow[id] = {dat[31:16], 7'b0, dat[8], 8'h00};
      wb_write(addr_of(id), dat, 4'hE);
    end
    // Partial lanes, pending lane kept out
    for (int unsigned i = 0; i < num_src; i += 5) begin
      id  = irq_id_t'(i);
      dat = $urandom();
      sel = {3'($urandom_range(1, 7)), 1'b0};
      wb_write(addr_of(id), dat, sel);
      if (sel[1]) shadow[id][8]     = dat[8];
      if (sel[2]) shadow[id][23:16] = dat[23:16];
      if (sel[3]) shadow[id][31:24] = dat[31:24];
    end
    for (int unsigned i = 0; i < num_src; i += 5) begin
      id = irq_id_t'(i);
      wb_read(addr_of(id), rd);
      if (rd !== shadow[id]) value_error("reg_access", shadow[id], rd);
    end
    wb_write(12'h040, $urandom(), 4'hF);  // Aliases source 0 if decoded wrong
    wb_read(12'h000, rd);
    if (rd !== shadow[0]) value_error("reg_access", shadow[0], rd);
    wb_read(12'h040, rd);
    if (rd !== 32'h0) value_error("reg_unmapped", 32'h0, rd);
    wb_read(12'hFFC, rd);
    if (rd !== 32'h0) value_error("reg_unmapped", 32'h0, rd);
    clear_all();
  endtask

  task automatic pulse_src(input irq_id_t id);
    @(negedge clk_i);
    irq_src_i[id] = 1'b1;
    @(negedge clk_i);
    irq_src_i[id] = 1'b0;
  endtask

  task automatic test_edge();
    level_t   lvl;
    wb_data_t rd;
    wb_data_t cfg;   // Word without the pending bit
    lvl          = level_t'($urandom_range(1, 255));
    cfg          = {lvl, priv_m, 5'b0, 1'b1, 8'h01, 8'h00};
    priv_lvl_i   = priv_m;
    mintthresh_i = '0;
    mil_i        = '0;
    set_src(4'd3, 1'b1, priv_m, lvl, 1'b1);
    pulse_src(4'd3);
    wait_req(1'b1, "edge_pending");
    wb_read(addr_of(4'd3), rd);
    if (rd !== (cfg | 32'h1)) value_error("edge_pending", cfg | 32'h1, rd);
    irq_ready_i = 1'b1;  // Core takes it
    @(negedge clk_i);
    irq_ready_i = 1'b0;
    if (irq_req_o !== 1'b0) plain_error("edge_retire: request stayed up after the core took it");
    wb_read(addr_of(4'd3), rd);
    if (rd !== cfg) value_error("edge_retire", cfg, rd);
    // Software clear
    pulse_src(4'd3);
    wait_req(1'b1, "edge_write_clear");
    wb_write(addr_of(4'd3), 32'h0, 4'h1);
    wb_read(addr_of(4'd3), rd);
    if (rd !== cfg) value_error("edge_write_clear", cfg, rd);
    wait_req(1'b0, "edge_write_clear");
    clear_all();
  endtask

  task automatic test_m_mode();
    level_t lvl;
    lvl          = level_t'($urandom_range(16, 255));
    priv_lvl_i   = priv_m;
    mintthresh_i = lvl - 8'd1;
    mil_i        = level_t'($urandom_range(0, lvl - 1));
    set_src(4'd6, 1'b0, priv_m, lvl, 1'b1);
    irq_src_i[6] = 1'b1;
    wait_req(1'b1, "m_mode");
    if (irq_cause_o !== pack_cause(priv_m, lvl, 4'd6)) begin
      value_error("m_mode", pack_cause(priv_m, lvl, 4'd6), irq_cause_o);
    end
    mil_i = lvl;  // Running level equal to the level
    no_req(6, "m_mode_equal_mil");
    mil_i        = '0;
    mintthresh_i = lvl;  // Threshold equal to the level
    no_req(6, "m_mode_equal_thresh");
    mintthresh_i = '0;
    clear_all();
  endtask

  // One source, one mode, expectation from the acceptance model
  task automatic offer_case(input string test, input priv_t mode, input priv_t tgt,
                            input logic sie, input level_t gap);
    level_t lvl;
    level_t top;
    level_t low;
    lvl          = level_t'($urandom_range(64, 200));
    top          = lvl - gap;  // Effective S threshold
    low          = level_t'($urandom_range(0, top));
    priv_lvl_i   = mode;
    sie_i        = sie;
    // M thresholds open in M-mode, shut elsewhere
    mintthresh_i = (mode == priv_m) ? 8'h00 : 8'hFF;
    mil_i        = (mode == priv_m) ? 8'h00 : 8'hFF;
    if ($urandom_range(0, 1) == 1) begin
      sintthresh_i = top;
      sil_i        = low;
    end else begin
      sintthresh_i = low;
      sil_i        = top;
    end
    set_src(4'd2, 1'b0, tgt, lvl, 1'b1);
    irq_src_i[2] = 1'b1;
    if (takes(mode, tgt, lvl)) begin
      wait_req(1'b1, test);
      if (irq_cause_o !== pack_cause(tgt, lvl, 4'd2)) begin
        value_error(test, pack_cause(tgt, lvl, 4'd2), irq_cause_o);
      end
    end else begin
      no_req(8, test);
    end
    clear_all();
  endtask

  task automatic test_modes();
    offer_case("s_mode_s_target", priv_s, priv_s, 1'b1, 8'd1);
    offer_case("s_mode_equal", priv_s, priv_s, 1'b1, 8'd0);
    offer_case("s_mode_sie_off", priv_s, priv_s, 1'b0, 8'd5);
    offer_case("s_mode_m_target", priv_s, priv_m, 1'b0, 8'd0);
    offer_case("s_mode_u_target", priv_s, priv_u, 1'b1, 8'd5);
    offer_case("u_mode_m_target", priv_u, priv_m, 1'b0, 8'd0);
    offer_case("u_mode_s_target", priv_u, priv_s, 1'b0, 8'd0);
    offer_case("u_mode_u_target", priv_u, priv_u, 1'b1, 8'd5);
    offer_case("m_mode_s_target", priv_m, priv_s, 1'b1, 8'd5);
    sie_i        = 1'b0;
    mintthresh_i = '0;
    mil_i        = '0;
  endtask

  task automatic test_select();
    level_t      top;
    int unsigned win;
    top        = level_t'($urandom_range(128, 255));
    sel_id     = {4'd4, 4'd10, 4'd7, 4'd12};  // Slots 3..0
    sel_lvl[0] = level_t'($urandom_range(1, 127));
    sel_lvl[1] = top;
    sel_lvl[2] = top;  // Tie with ID 7
    sel_lvl[3] = top - level_t'($urandom_range(1, 64));
    priv_lvl_i   = priv_m;
    mintthresh_i = '0;
    mil_i        = '0;
    for (int unsigned i = 0; i < 4; i++) begin
      set_src(sel_id[i], 1'b0, priv_m, sel_lvl[i], 1'b1);
    end
    for (int unsigned i = 0; i < 4; i++) begin
      irq_src_i[sel_id[i]] = 1'b1;  // All at once
    end
    win = best_slot(4'hF);
    wait_req(1'b1, "select");
    if (irq_cause_o !== pack_cause(priv_m, sel_lvl[win], sel_id[win])) begin
      value_error("select", pack_cause(priv_m, sel_lvl[win], sel_id[win]), irq_cause_o);
    end
    // Winner leaves, next one steps in
    irq_src_i[sel_id[win]] = 1'b0;
    wait_req(1'b0, "select_next");
    wait_req(1'b1, "select_next");
    win = best_slot(4'hF & ~(4'b1 << win));
    if (irq_cause_o !== pack_cause(priv_m, sel_lvl[win], sel_id[win])) begin
      value_error("select_next", pack_cause(priv_m, sel_lvl[win], sel_id[win]), irq_cause_o);
    end
    clear_all();
  endtask

  task automatic test_backpressure();
    level_t      lo;
    level_t      hi;
    int unsigned bad;
    lo           = level_t'($urandom_range(1, 100));
    hi           = level_t'($urandom_range(101, 200));
    priv_lvl_i   = priv_m;
    mintthresh_i = '0;
    mil_i        = '0;
    set_src(4'd8, 1'b0, priv_m, lo, 1'b1);
    set_src(4'd11, 1'b0, priv_m, hi, 1'b1);
    set_src(4'd13, 1'b0, priv_m, hi + 8'd1, 1'b1);
    irq_src_i[8] = 1'b1;
    wait_req(1'b1, "hold");
    if (irq_cause_o !== pack_cause(priv_m, lo, 4'd8)) begin
      value_error("hold", pack_cause(priv_m, lo, 4'd8), irq_cause_o);
    end
    bad = 0;
    for (int unsigned i = 0; i < 12; i++) begin
      @(negedge clk_i);
      if (irq_req_o !== 1'b1 || irq_cause_o !== pack_cause(priv_m, lo, 4'd8)) bad++;
    end
    if (bad != 0) plain_error("hold: offer changed while irq_ready_i was low");
    irq_src_i[8] = 1'b0;  // Withdrawn before the core took it
    wait_req(1'b0, "withdraw");
    irq_src_i[11] = 1'b1;
    wait_req(1'b1, "after_kill");
    if (irq_cause_o !== pack_cause(priv_m, hi, 4'd11)) begin
      value_error("after_kill", pack_cause(priv_m, hi, 4'd11), irq_cause_o);
    end
    // Higher source replaces the waiting offer
    irq_src_i[13] = 1'b1;
    wait_req(1'b0, "replace");
    wait_req(1'b1, "replace");
    if (irq_cause_o !== pack_cause(priv_m, hi + 8'd1, 4'd13)) begin
      value_error("replace", pack_cause(priv_m, hi + 8'd1, 4'd13), irq_cause_o);
    end
    irq_src_i   = '0;
    irq_ready_i = 1'b1;
    @(negedge clk_i);
    irq_ready_i = 1'b0;
    if (irq_req_o !== 1'b0) plain_error("replace: request stayed up after the core took it");
    clear_all();
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    seed = 32'h0faba809;
    void'($urandom(seed));
    errors       = 0;
    fails        = 0;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    wb_sel_i     = '0;
    irq_src_i    = '0;
    priv_lvl_i   = priv_m;
    mintthresh_i = '0;
    sintthresh_i = '0;
    mil_i        = '0;
    sil_i        = '0;
    sie_i        = 1'b0;
    irq_ready_i  = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    if (wb_ack_o !== 1'b0 || irq_req_o !== 1'b0) plain_error("Outputs not low after reset");
    test_regs();
    test_edge();
    test_m_mode();
    test_modes();
    test_select();
    test_backpressure();
    $display("Errors: %0d wrong values, %0d other failures", errors, fails);
    if (errors == 0 && fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog for the whole run
  initial begin
    #100000;
    $display("Simulation stopped by the watchdog");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
